// ==== spi_flash_ctrl.f ====
+incdir+hdl
hdl/spi_flash_pkg.sv
hdl/spi_sclk_gen.sv
hdl/spi_frame_builder.sv
hdl/spi_shift_engine.sv
hdl/spi_flash_ctrl.sv
sim/flash_model.sv
sim/tb_spi_flash_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SPI flash controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -j 0 \
	--top-module tb_spi_flash_ctrl \
	-f spi_flash_ctrl.f \
	-o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$LOG"
	echo "Simulation exited with an error"
	exit 1
fi

cat "$LOG"

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
	exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
	echo "No pass line found in $LOG"
	exit 1
fi
exit 0

// ==== sim/tb_spi_flash_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_flash_defs.svh"

module tb_spi_flash_ctrl;

	import spi_flash_pkg::*;

	localparam real WD_NS = 20.0 * 96 * `SPI_CLK_DIV * 4.0 * 2;
	localparam int IDLE_LIMIT = 200 * `SPI_CLK_DIV;

	logic clk;
	logic rst;
	logic [`SPI_DATA_W-1:0] data_in;
	logic [`SPI_ADDR_W-1:0] address;
	logic [`SPI_COM_W-1:0] command;
	logic [`SPI_CTYP_W-1:0] commtype;
	logic validflag;
	wire [`SPI_DATA_W-1:0] data_out;
	wire validflag_out;
	wire tready;
	wire sclk;
	wire ss;
	wire mosi;
	wire miso;
	logic [`SPI_BCNT_W-1:0] rd_bits;
	wire [`SPI_FRAME_W-1:0] fm_bits;
	wire [`SPI_BCNT_W-1:0] fm_count;

	int value_errs = 0;
	int other_errs = 0;
	int vf_count = 0;
	int frames = 0;
	logic [`SPI_DATA_W-1:0] vf_data;

	spi_flash_ctrl UUT (
		.clk(clk), .rst(rst), .data_in(data_in), .address(address),
		.command(command), .commtype(commtype), .validflag(validflag),
		.data_out(data_out), .validflag_out(validflag_out), .tready(tready),
		.sclk(sclk), .ss(ss), .mosi(mosi), .miso(miso)
	);

	flash_model u_flash (
		.sclk(sclk), .ss(ss), .mosi(mosi), .rd_bits(rd_bits),
		.miso(miso), .bits(fm_bits), .count(fm_count)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		if (validflag_out) begin
			vf_count <= vf_count + 1;
			vf_data  <= data_out;
		end
	end

	always @(negedge ss) frames <= frames + 1;

	initial begin
		#(WD_NS);
		$display("Timeout: tests did not complete within %0t", $time);
		$display("*** FAILED ***");
		$finish;
	end

	task automatic check_word(input string name, input logic [`SPI_DATA_W-1:0] got,
			input logic [`SPI_DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_frame(input string name, input spi_frame_u got, input spi_frame_u exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_count(input string name, input logic [`SPI_BCNT_W-1:0] got,
			input logic [`SPI_BCNT_W-1:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
			value_errs++;
		end
	endtask

	// Bits on mosi per command type
	function automatic int bits_for(input cmd_type_e t);
		case (t)
			CT_CMD, CT_CMD_RD:         return 8;
			CT_CMD_ADDR_RD:            return 32;
			CT_CMD_DATA, CT_CMD_ADDR:  return 40;
			CT_CMD_ADDR_DATA:          return 64;
			default:                   return 0;
		endcase
	endfunction

	function automatic spi_frame_u frame_for(input cmd_type_e t, input logic [7:0] op,
			input logic [23:0] addr, input logic [31:0] data);
		logic [63:0] raw;
		int n;
		n = bits_for(t);
		raw = (t == CT_CMD_DATA) ? {op, data, 24'h0} : {op, addr, data};
		raw = raw & ~(64'hffff_ffff_ffff_ffff >> n); // Keep the bits actually sent
		return spi_frame_u'(raw);
	endfunction

	task automatic send_req(input logic [2:0] t, input logic [7:0] op,
			input logic [23:0] addr, input logic [31:0] data);
		while (!tready) begin
			@(posedge clk);
			#1;
		end
		commtype  = t;
		command   = op;
		address   = addr;
		data_in   = data;
		validflag = 1'b1;
		@(posedge clk);
		#1;
		validflag = 1'b0;
	endtask

	task automatic wait_idle();
		int i;
		i = 0;
		while (!tready && i < IDLE_LIMIT) begin
			@(posedge clk);
			#1;
			i++;
		end
		if (!tready) begin
			$display("tready did not return high at %0t", $time);
			other_errs++;
		end
	endtask

	task automatic run_one(input cmd_type_e t, input logic [7:0] op,
			input logic [23:0] addr, input logic [31:0] data);
		int n;
		int total;
		int vf0;
		logic rd;
		logic [63:0] got;
		logic [31:0] reply;
		n = bits_for(t);
		rd = (t == CT_CMD_RD) || (t == CT_CMD_ADDR_RD);
		total = rd ? n + 32 : n;
		vf0 = vf_count;
		rd_bits = rd ? n[6:0] : 7'd0;
		send_req(t, op, addr, data);
		wait_idle();
		check_count("flash_count", fm_count, total[6:0]);
		got = (fm_bits >> (total - n)) << (64 - n);
		check_frame("mosi_frame", spi_frame_u'(got), frame_for(t, op, addr, data));
		if (rd) begin
			reply = {4{op}} ^ ((t == CT_CMD_ADDR_RD) ? {8'h00, addr} : 32'h0);
			if (vf_count != vf0 + 1) begin
				$display("Read type %0d gave %0d result pulses", t, vf_count - vf0);
				other_errs++;
			end
			check_word("data_out", vf_data, reply);
		end else if (vf_count != vf0) begin
			$display("Write type %0d raised validflag_out", t);
			other_errs++;
		end
	endtask

	task automatic reset_values();
		check_bit("tready", tready, 1'b1);
		check_bit("ss", ss, 1'b1);
		check_bit("sclk", sclk, 1'b0);
		check_bit("validflag_out", validflag_out, 1'b0);
		check_word("data_out", data_out, '1);
	endtask

	task automatic each_command_type();
		run_one(CT_CMD, 8'h06, 24'h123456, 32'hdeadbeef);
		run_one(CT_CMD_DATA, 8'h01, 24'h0f0f0f, 32'ha5c3_1e77);
		run_one(CT_CMD_ADDR_DATA, 8'h02, 24'habcdef, 32'h1234_5678);
		run_one(CT_CMD_ADDR, 8'hd8, 24'h7e5501, 32'h9a00_0000);
		run_one(CT_CMD_RD, 8'h9f, 24'hffffff, 32'h0);
		run_one(CT_CMD_ADDR_RD, 8'h03, 24'h00a5f0, 32'h0);
	endtask

	task automatic busy_request_dropped();
		int f0;
		f0 = frames;
		rd_bits = 7'd0;
		send_req(CT_CMD_ADDR_DATA, 8'h02, 24'h00c0de, 32'hcafe_f00d);
		repeat (6) @(posedge clk);
		#1;
		commtype  = CT_CMD;
		command   = 8'hff;
		validflag = 1'b1; // tready is low here
		@(posedge clk);
		#1;
		validflag = 1'b0;
		wait_idle();
		repeat (8) @(posedge clk);
		#1;
		check_count("flash_count", fm_count, 7'd64);
		check_frame("mosi_frame", spi_frame_u'(fm_bits),
			frame_for(CT_CMD_ADDR_DATA, 8'h02, 24'h00c0de, 32'hcafe_f00d));
		if (frames != f0 + 1) begin
			$display("Busy request started %0d frames instead of one", frames - f0);
			other_errs++;
		end
	endtask

	task automatic unused_type_dropped();
		int f0;
		f0 = frames;
		send_req(3'b111, 8'h55, 24'h0, 32'h0);
		repeat (20) @(posedge clk);
		#1;
		check_bit("tready", tready, 1'b1);
		check_bit("ss", ss, 1'b1);
		if (frames != f0) begin
			$display("Unused command type lowered ss");
			other_errs++;
		end
	endtask

	task automatic random_back_to_back();
		cmd_type_e t;
		for (int i = 0; i < 10; i++) begin
			t = cmd_type_e'(3'($urandom % 6));
			run_one(t, 8'($urandom), 24'($urandom), $urandom);
		end
	endtask

	initial begin
		void'($urandom(32'hd72e0d17));
		rst       = 1'b1;
		data_in   = '0;
		address   = '0;
		command   = '0;
		commtype  = 3'b111;
		validflag = 1'b0;
		rd_bits   = '0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		reset_values();
		each_command_type();
		busy_request_dropped();
		unused_type_dropped();
		random_back_to_back();
		$display("Errors: %0d value, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/flash_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_flash_defs.svh"

module flash_model (
	input  wire                          sclk,
	input  wire                          ss,
	input  wire                          mosi,
	input  wire [`SPI_BCNT_W-1:0]        rd_bits, // Bits before the answer, 0 if none
	output logic                         miso,
	output logic [`SPI_FRAME_W-1:0]      bits,
	output logic [`SPI_BCNT_W-1:0]       count
);

	logic [`SPI_DATA_W-1:0] reply;

	initial begin
		miso  = 1'b0;
		bits  = '0;
		count = '0;
		reply = '0;
	end

	// ss falling clears the capture, sclk rising takes one bit
	always @(posedge sclk or negedge ss) begin
		if (!sclk) begin
			bits  <= '0;
			count <= '0;
		end else if (!ss) begin
			bits  <= {bits[`SPI_FRAME_W-2:0], mosi};
			count <= count + 1'b1;
		end
	end

	// Answer shifts out on falling edges once the request bits are in
	always @(negedge sclk) begin
		logic [`SPI_DATA_W-1:0] word;
		int idx;
		if (!ss && rd_bits != 0 && count >= rd_bits && count < rd_bits + `SPI_DATA_W) begin
			idx = count - rd_bits;
			if (idx == 0) begin
				if (rd_bits == 8) begin
					word = {4{bits[7:0]}};
				end else begin
					word = {4{bits[31:24]}} ^ {8'h00, bits[23:0]};
				end
				reply = word;
			end
			miso <= reply[`SPI_DATA_W-1-idx];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/spi_flash_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_flash_defs.svh"

module spi_flash_ctrl (
	input  wire                     clk,
	input  wire                     rst,

	// Controller side
	input  wire [`SPI_DATA_W-1:0]   data_in,
	input  wire [`SPI_ADDR_W-1:0]   address,
	input  wire [`SPI_COM_W-1:0]    command,
	input  wire [`SPI_CTYP_W-1:0]   commtype,
	input  wire                     validflag,
	output logic [`SPI_DATA_W-1:0]  data_out,
	output logic                    validflag_out,
	output logic                    tready,

	// Flash pins
	output logic                    sclk,
	output logic                    ss,
	output logic                    mosi,
	input  wire                     miso
);

	import spi_flash_pkg::*;

	spi_req_t    req;
	frame_desc_t desc;
	logic        start;
	logic        active;
	logic        sclk_rise;
	logic        sclk_fall;

	// Code 110 and CT_NONE are dropped by the builder
	assign req = '{
		ctype:   cmd_type_e'(commtype),
		command: command,
		address: address,
		data:    data_in
	};

	spi_frame_builder u_builder (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.req_valid (validflag),
		.ready     (tready),
		.desc      (desc),
		.start     (start)
	);

	spi_shift_engine u_engine (
		.clk           (clk),
		.rst           (rst),
		.desc          (desc),
		.start         (start),
		.sclk_rise     (sclk_rise),
		.sclk_fall     (sclk_fall),
		.miso          (miso),
		.active        (active),
		.ss            (ss),
		.mosi          (mosi),
		.data_out      (data_out),
		.validflag_out (validflag_out),
		.tready        (tready)
	);

	spi_sclk_gen u_sclk_gen (
		.clk       (clk),
		.rst       (rst),
		.active    (active),
		.sclk      (sclk),
		.sclk_rise (sclk_rise),
		.sclk_fall (sclk_fall)
	);

endmodule

`default_nettype wire

// ==== hdl/spi_shift_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_flash_defs.svh"

module spi_shift_engine (
	input  wire                              clk,
	input  wire                              rst,
	input  wire spi_flash_pkg::frame_desc_t  desc,
	input  wire                              start,
	input  wire                              sclk_rise,
	input  wire                              sclk_fall,
	input  wire                              miso,
	output logic                             active,
	output logic                             ss,
	output logic                             mosi,
	output logic [`SPI_DATA_W-1:0]           data_out,
	output logic                             validflag_out,
	output logic                             tready
);

	localparam int RX_CNT_W = $clog2(`SPI_DATA_W + 1);

	typedef enum logic [1:0] {
		IDLE,
		SEND,
		RECV,
		DONE
	} state_t;

	state_t                   state;
	logic [`SPI_FRAME_W-1:0]  tx_sr;     // MSB is the next bit out
	logic [`SPI_BCNT_W-1:0]   bits_left; // Includes the bit on mosi now
	logic                     want_rx;
	logic [RX_CNT_W-1:0]      rx_left;
	logic [`SPI_DATA_W-1:0]   rx_sr;

	// Low as soon as a start is pending, back high once ss has risen
	assign tready = (state == IDLE) && !start;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state         <= IDLE;
			ss            <= 1'b1;
			active        <= 1'b0;
			mosi          <= 1'b0;
			validflag_out <= 1'b0;
			data_out      <= '1; // Erased flash reads as ones
		end else begin
			validflag_out <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						state <= SEND;
					end
				end
				SEND: begin
					if (ss) begin
						// First bit goes out together with ss falling
						ss     <= 1'b0;
						active <= 1'b1;
						mosi   <= tx_sr[`SPI_FRAME_W-1];
					end else if (sclk_fall) begin
						if (bits_left == `SPI_BCNT_W'd1) begin
							if (want_rx) begin
								state <= RECV; // ss stays low for the answer
							end else begin
								ss     <= 1'b1;
								active <= 1'b0;
								state  <= DONE;
							end
						end else begin
							mosi <= tx_sr[`SPI_FRAME_W-1];
						end
					end
				end
				RECV: begin
					if (sclk_fall && rx_left == '0) begin
						ss            <= 1'b1;
						active        <= 1'b0;
						data_out      <= rx_sr;
						validflag_out <= 1'b1;
						state         <= DONE;
					end
				end
				DONE: begin
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (start) begin
					tx_sr     <= desc.frame;
					bits_left <= desc.nbits;
					want_rx   <= desc.expect_answer;
					rx_left   <= RX_CNT_W'(`SPI_DATA_W);
				end
			end
			SEND: begin
				if (ss) begin
					tx_sr <= tx_sr << 1;
				end else if (sclk_fall) begin
					tx_sr     <= tx_sr << 1;
					bits_left <= bits_left - 1'b1;
				end
			end
			RECV: begin
				// Slave drives on the falling edge, sample on the rising one
				if (sclk_rise && rx_left != '0) begin
					rx_sr   <= {rx_sr[`SPI_DATA_W-2:0], miso};
					rx_left <= rx_left - 1'b1;
				end
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/spi_frame_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_flash_defs.svh"

module spi_frame_builder (
	input  wire                         clk,
	input  wire                         rst,
	input  wire spi_flash_pkg::spi_req_t req,
	input  wire                         req_valid,
	input  wire                         ready,
	output spi_flash_pkg::frame_desc_t  desc,
	output logic                        start
);

	import spi_flash_pkg::*;

	// Bits on mosi per type
	localparam logic [`SPI_BCNT_W-1:0] NB_CMD       = `SPI_BCNT_W'd8;
	localparam logic [`SPI_BCNT_W-1:0] NB_CMD_ADDR  = `SPI_BCNT_W'd32; // Read setup
	localparam logic [`SPI_BCNT_W-1:0] NB_40        = `SPI_BCNT_W'd40;
	localparam logic [`SPI_BCNT_W-1:0] NB_FULL      = `SPI_BCNT_W'd64;

	logic                     accept;
	cmd_type_e                ctype_q;
	logic [`SPI_COM_W-1:0]    opcode_q;
	logic [`SPI_ADDR_W-1:0]   addr_q;
	logic [`SPI_DATA_W-1:0]   data_q;

	function automatic logic type_known(input cmd_type_e t);
		case (t)
			CT_CMD, CT_CMD_RD, CT_CMD_ADDR_RD,
			CT_CMD_DATA, CT_CMD_ADDR_DATA, CT_CMD_ADDR: type_known = 1'b1;
			default:                                    type_known = 1'b0;
		endcase
	endfunction

	assign accept = req_valid && ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ctype_q <= CT_NONE;
			start   <= 1'b0;
		end else begin
			start <= accept && type_known(req.ctype); // Unknown codes never launch
			if (accept) begin
				ctype_q <= req.ctype;
			end
		end
	end

	// Opcode, address and data of the accepted request
	always_ff @(posedge clk) begin
		if (accept) begin
			opcode_q <= req.command;
			addr_q   <= req.address;
			data_q   <= req.data;
		end
	end

	always_comb begin
		desc.frame.addr_v   = '{opcode: opcode_q, address: addr_q, data: data_q};
		desc.nbits          = '0;
		desc.expect_answer  = 1'b0;
		case (ctype_q)
			CT_CMD: begin
				desc.nbits = NB_CMD;
			end
			CT_CMD_RD: begin
				desc.nbits         = NB_CMD;
				desc.expect_answer = 1'b1;
			end
			CT_CMD_ADDR_RD: begin
				desc.nbits         = NB_CMD_ADDR;
				desc.expect_answer = 1'b1;
			end
			CT_CMD_DATA: begin
				// Data word sits right behind the opcode here
				desc.frame.direct_v = '{opcode: opcode_q, data: data_q, pad: '0};
				desc.nbits          = NB_40;
			end
			CT_CMD_ADDR_DATA: begin
				desc.nbits = NB_FULL;
			end
			CT_CMD_ADDR: begin
				desc.nbits = NB_40; // Opcode, address and top data byte
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/spi_sclk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_flash_defs.svh"

module spi_sclk_gen (
	input  wire  clk,
	input  wire  rst,
	input  wire  active,
	output logic sclk,
	output logic sclk_rise,
	output logic sclk_fall
);

	localparam int CNT_W = ($clog2(`SPI_CLK_DIV) > 0) ? $clog2(`SPI_CLK_DIV) : 1;
	localparam logic [CNT_W-1:0] RISE_AT = CNT_W'(`SPI_CLK_DIV / 2 - 1);
	localparam logic [CNT_W-1:0] FALL_AT = CNT_W'(`SPI_CLK_DIV - 1);

	logic [CNT_W-1:0] cnt;

	// Held at zero while idle, so each transfer opens with a full low half
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt <= '0;
		end else if (!active || cnt == FALL_AT) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Strobes lead the sclk edge by one clk
	assign sclk_rise = active && (cnt == RISE_AT);
	assign sclk_fall = active && (cnt == FALL_AT);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sclk <= 1'b0;
		end else if (!active) begin
			sclk <= 1'b0; // Mode 0 idles low
		end else if (sclk_rise) begin
			sclk <= 1'b1;
		end else if (sclk_fall) begin
			sclk <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/spi_flash_pkg.sv ====
`default_nettype none

`include "spi_flash_defs.svh"

package spi_flash_pkg;

	// Command types as encoded on commtype
	typedef enum logic [`SPI_CTYP_W-1:0] {
		CT_CMD           = 3'b000, // Opcode only
		CT_CMD_RD        = 3'b001, // Opcode, then 32-bit answer
		CT_CMD_ADDR_RD   = 3'b010, // Opcode + address, then answer
		CT_CMD_DATA      = 3'b011, // Opcode + data word
		CT_CMD_ADDR_DATA = 3'b100, // Opcode + address + data word
		CT_CMD_ADDR      = 3'b101,
		CT_NONE          = 3'b111  // Idle marker, never starts a transfer
	} cmd_type_e;

	// One controller request, 67 bits
	typedef struct packed {
		cmd_type_e                ctype;
		logic [`SPI_COM_W-1:0]    command;
		logic [`SPI_ADDR_W-1:0]   address;
		logic [`SPI_DATA_W-1:0]   data;
	} spi_req_t;

	// Frame with address after the opcode
	typedef struct packed {
		logic [`SPI_COM_W-1:0]    opcode;
		logic [`SPI_ADDR_W-1:0]   address;
		logic [`SPI_DATA_W-1:0]   data;
	} frame_addr_t;

	// Frame with data right after the opcode
	typedef struct packed {
		logic [`SPI_COM_W-1:0]    opcode;
		logic [`SPI_DATA_W-1:0]   data;
		logic [`SPI_ADDR_W-1:0]   pad;
	} frame_direct_t;

	// Same 64 bits, read either way
	typedef union packed {
		frame_addr_t   addr_v;
		frame_direct_t direct_v;
	} spi_frame_u;

	typedef struct packed {
		spi_frame_u               frame;
		logic [`SPI_BCNT_W-1:0]   nbits;         // Bits sent on mosi, MSB first
		logic                     expect_answer; // 32 miso bits follow
	} frame_desc_t;

endpackage

`default_nettype wire

// ==== hdl/spi_flash_defs.svh ====
`ifndef SPI_FLASH_DEFS_SVH
`define SPI_FLASH_DEFS_SVH

// Controller side field widths
`define SPI_DATA_W 32
`define SPI_ADDR_W 24
`define SPI_COM_W 8
`define SPI_CTYP_W 3

// Longest frame is opcode + address + data
`define SPI_FRAME_W 64

// Bit counter holds 1 to 64
`define SPI_BCNT_W 7

// clk cycles per sclk period, even and at least 2
`define SPI_CLK_DIV 4

`endif
